//--- list.f
+incdir+logic
logic/cache_addr_pkg.sv
logic/cache_ctrl_pkg.sv
logic/cache_ifs.sv
logic/cache_way.sv
logic/hit_write_buffer.sv
logic/cache_ctrl.sv
logic/cache_top.sv
test/cache_assertions.sv
test/cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_tb -f list.f \
    --Mdir obj_dir -o cache_sim

./obj_dir/cache_sim > sim.log 2>&1 || true
cat sim.log

if grep -qxF '>>> PASS' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- test/cache_tests.txt
# name  op  addr  wstrb  wdata  expected_rdata   (all numbers in hex)
# op: r read, h read that must hit, w write (expected column unused)
cold_rd     r 00001238 0 00000000 ffffedc7
hit_rd      h 00001230 0 00000000 ffffedcf
wr_hit      w 00001234 3 0000beef 00000000
raw_rd      h 00001234 0 00000000 ffffbeef
wr_miss     w 00005678 c 12340000 00000000
miss_rd     h 00005678 0 00000000 1234a987
miss_rd_nb  h 0000567c 0 00000000 ffffa983
ev_a_wr     w 00002234 f cafef00d 00000000
ev_b_rd     r 00003230 0 00000000 ffffcdcf
ev_c_rd     r 00001234 0 00000000 ffffbeef
ev_a_rd     r 00002234 0 00000000 cafef00d
ev_b_rd2    r 0000323c 0 00000000 ffffcdc3
ev_c_rd2    r 00001238 0 00000000 ffffedc7

//--- test/cache_tb.sv
// Testbench for the two-way write-back data cache
// Bus memory model, shadow memory and request checks driven from a data file
module cache_tb;

    logic         clk;
    logic         resetn;
    logic         valid;
    logic         op;
    logic [  7:0] index;
    logic [ 19:0] tag;
    logic [  3:0] offset;
    logic [  3:0] wstrb;
    logic [ 31:0] wdata;
    logic         addr_ok;
    logic         data_ok;
    logic [ 31:0] rdata;
    logic         rd_req;
    logic [ 31:0] rd_addr;
    logic         rd_rdy;
    logic         ret_valid;
    logic         ret_last;
    logic [ 31:0] ret_data;
    logic         wr_req;
    logic [ 31:0] wr_addr;
    logic [127:0] wr_data;
    logic         wr_rdy;

    localparam int TIMEOUT = 200;       // Cycles per wait

    logic [31:0] mem    [logic [31:0]]; // Lines written back by the cache
    logic [31:0] shadow [logic [31:0]]; // Latest CPU store bytes
    string       acc_name;              // Last accepted request
    logic [31:0] acc_addr;

    cache_top cache_top_inst (.*);

    bind cache_top cache_assertions assertions_inst (
        .clk     (clk),
        .resetn  (resetn),
        .data_ok (data_ok),
        .rd_req  (rd_req),
        .rd_rdy  (rd_rdy),
        .wr_req  (wr_req),
        .wr_rdy  (wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Untouched memory word, every address bit matters
    function automatic logic [31:0] init_word(logic [31:0] a);
        return ~a;
    endfunction

    function automatic logic [31:0] mem_word(logic [31:0] a);
        return mem.exists(a) ? mem[a] : init_word(a);
    endfunction

    function automatic logic [31:0] shadow_word(logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : init_word(a);
    endfunction

    function automatic logic [127:0] shadow_line(logic [31:0] line);
        logic [127:0] blk;
        for (int k = 0; k < 4; k++) begin
            blk[32*k +: 32] = shadow_word(line + 32'(4*k));
        end
        return blk;
    endfunction

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_equal(string name, logic [127:0] expected, logic [127:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            stop_with_failure("a checked value did not match");
        end
    endtask

    task automatic random_delay();
        int n;
        n = $urandom_range(3, 0);
        repeat (n) @(negedge clk);
    endtask

    // Victim write-back, one 128-bit block
    task automatic serve_write();
        check_equal({acc_name, " wr_addr offset"}, 0, wr_addr[3:0]);
        check_equal({acc_name, " wr_addr index"}, acc_addr[11:4], wr_addr[11:4]);
        check_equal({acc_name, " wr_data"}, shadow_line(wr_addr), wr_data);
        for (int k = 0; k < 4; k++) begin
            mem[wr_addr + 32'(4*k)] = wr_data[32*k +: 32];
        end
        random_delay();
        wr_rdy = 1'b1;
        @(negedge clk);
        wr_rdy = 1'b0;
    endtask

    // Line read, then four beats with random gaps
    task automatic serve_read();
        logic [31:0] line;
        line = rd_addr;
        check_equal({acc_name, " rd_addr"}, {acc_addr[31:4], 4'h0}, rd_addr);
        random_delay();
        rd_rdy = 1'b1;
        @(negedge clk);
        rd_rdy = 1'b0;
        for (int k = 0; k < 4; k++) begin
            random_delay();
            ret_valid = 1'b1;
            ret_last  = (k == 3);
            ret_data  = mem_word(line + 32'(4*k));
            @(negedge clk);
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    endtask

    initial begin : bus_model
        void'($urandom(74581));
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        @(posedge resetn);
        forever begin
            @(negedge clk);
            if (wr_req) begin
                serve_write();
            end else if (rd_req) begin
                serve_read();
            end
        end
    end

    // Starts on a falling edge, samples 1 unit later once inputs settle
    task automatic run_request(string name, string kind, logic [31:0] addr,
                               logic [3:0] strb, logic [31:0] data, logic [31:0] expected);
        int          t;
        int          lat;
        logic [31:0] merged;
        @(negedge clk);
        valid  = 1'b1;
        op     = (kind == "w");
        tag    = addr[31:12];
        index  = addr[11:4];
        offset = addr[3:0];
        wstrb  = strb;
        wdata  = data;
        t = 0;
        #1;
        while (!addr_ok) begin
            t++;
            if (t > TIMEOUT) begin
                stop_with_failure({"timeout waiting for addr_ok in ", name});
            end
            @(negedge clk);
            #1;
        end
        acc_name = name;
        acc_addr = addr;
        if (kind == "w") begin
            merged = shadow_word({addr[31:2], 2'b00});
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    merged[8*i +: 8] = data[8*i +: 8];
                end
            end
            shadow[{addr[31:2], 2'b00}] = merged;
        end
        @(negedge clk);
        valid = 1'b0;
        #1;
        lat = 1;
        while (!data_ok) begin
            lat++;
            if (lat > TIMEOUT) begin
                stop_with_failure({"timeout waiting for data_ok in ", name});
            end
            @(negedge clk);
            #1;
        end
        if (kind != "w") begin
            check_equal(name, expected, rdata);
        end
        if (kind != "r") begin
            check_equal({name, " latency"}, 1, lat);   // Hit or store done in LOOKUP
        end
        if (kind == "h") begin
            check_equal({name, " rd_req"}, 0, rd_req);
        end
    endtask

    initial begin : main
        int          fd;
        int          n_tests;
        string       text;
        string       name;
        string       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        logic [3:0]  strb;
        n_tests   = 0;
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = 1'b0;
        index     = '0;
        tag       = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        fd = $fopen("test/cache_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open test/cache_tests.txt");
        end
        repeat (3) @(negedge clk);
        resetn = 1'b1;
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text[0] == "#") begin
                continue;
            end
            if ($sscanf(text, "%s %s %h %h %h %h", name, kind, addr, strb, data,
                        expected) != 6) begin
                stop_with_failure({"malformed line in test file: ", text});
            end
            run_request(name, kind, addr, strb, data, expected);
            n_tests++;
        end
        $fclose(fd);
        if (n_tests > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_with_failure("no tests were run");
        end
    end

endmodule

//--- test/cache_assertions.sv
// Protocol checks on the cache top-level bus and CPU ports
module cache_assertions (
    input logic clk,
    input logic resetn,
    input logic data_ok,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req,
    input logic wr_rdy
);

    // Write-back and refill never overlap
    req_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req))
        else $error("rd_req and wr_req high in the same cycle");

    rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    wr_req_held: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req)
        else $error("wr_req dropped before wr_rdy");

    // First cycle out of reset is idle
    no_early_data_ok: assert property (@(posedge clk) !resetn |=> !data_ok)
        else $error("data_ok in the cycle right after reset");

endmodule

//--- logic/cache_top.sv
// Two-way set-associative write-back data cache
// Controller, two ways and the hit store buffer
module cache_top (
    input  logic         clk,
    input  logic         resetn,

    input  logic         valid,
    input  logic         op,            // 1 for store
    input  logic [  7:0] index,
    input  logic [ 19:0] tag,
    input  logic [  3:0] offset,
    input  logic [  3:0] wstrb,
    input  logic [ 31:0] wdata,
    output logic         addr_ok,
    output logic         data_ok,
    output logic [ 31:0] rdata,

    output logic         rd_req,
    output logic [ 31:0] rd_addr,
    input  logic         rd_rdy,
    input  logic         ret_valid,
    input  logic         ret_last,
    input  logic [ 31:0] ret_data,

    output logic         wr_req,
    output logic [ 31:0] wr_addr,
    output logic [127:0] wr_data,
    input  logic         wr_rdy
);

    cache_way_if way0_if ();
    cache_way_if way1_if ();
    hit_write_if hw_if ();

    cache_ctrl ctrl_inst (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .way0      (way0_if),
        .way1      (way1_if),
        .hw        (hw_if)
    );

    cache_way way0_inst (
        .clk    (clk),
        .resetn (resetn),
        .p      (way0_if)
    );

    cache_way way1_inst (
        .clk    (clk),
        .resetn (resetn),
        .p      (way1_if)
    );

    hit_write_buffer hw_buf_inst (
        .clk    (clk),
        .resetn (resetn),
        .hw     (hw_if)
    );

endmodule

//--- logic/cache_ctrl.sv
// Cache controller
// Main FSM, request and miss buffers, victim LFSR, RAM port control and bus side
`include "cache_defines.svh"

module cache_ctrl
    import cache_addr_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  logic        valid,
    input  logic        op,             // 1 for store
    input  index_t      index,
    input  tag_t        tag,
    input  offset_t     offset,
    input  strb_t       wstrb,
    input  word_t       wdata,
    output logic        addr_ok,
    output logic        data_ok,
    output word_t       rdata,
    output logic        rd_req,
    output word_t       rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  word_t       ret_data,
    output logic        wr_req,
    output word_t       wr_addr,
    output block_t      wr_data,
    input  logic        wr_rdy,
    cache_way_if.ctrl   way0,
    cache_way_if.ctrl   way1,
    hit_write_if.src    hw
);

    main_state_t state;
    main_state_t state_next;

    cpu_op_t    req_op;
    index_t     req_index;
    tag_t       req_tag;
    offset_t    req_offset;
    strb_t      req_wstrb;
    word_t      req_wdata;
    bank_t      req_bank;

    way_t       victim_way;
    bank_t      refill_cnt;         // Beats already returned
    logic [2:0] lfsr;

    logic       accept;
    logic       conflict;
    logic       way0_hit;
    logic       way1_hit;
    logic       hit;
    block_t     hit_block;
    word_t      hit_word;
    word_t      refill_word;
    tag_t       victim_tag;
    logic       victim_dirty;
    logic       refill_we;
    logic       tag_we;
    logic       rd_en;
    index_t     rd_index;
    index_t     wr_index;
    word_t      bank_wdata;
    logic [1:0] refill_sel;         // One-hot way of the refill
    logic [1:0] hit_sel;            // One-hot way of the pending store
    strb_t [`BANKS-1:0] refill_bank_we;
    strb_t [`BANKS-1:0] hit_bank_we;

    assign req_bank = req_offset[3:2];

    // Read of the bank the store buffer is writing this cycle
    assign conflict = hw.active && (op == OP_READ) && (offset[3:2] == hw.wb_bank);
    assign addr_ok  = (state == IDLE) && !conflict;
    assign accept   = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            IDLE:    state_next = accept ? LOOKUP : IDLE;
            LOOKUP:  state_next = hit ? IDLE : MISS;
            MISS:    state_next = (!victim_dirty || wr_rdy) ? REPLACE : MISS;
            REPLACE: state_next = rd_rdy ? REFILL : REPLACE;
            REFILL:  state_next = (ret_valid && ret_last) ? IDLE : REFILL;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op     <= cpu_op_t'(op);
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_way <= 1'b0;
            refill_cnt <= '0;
            lfsr       <= `LFSR_SEED;
        end else begin
            if (state == LOOKUP && !hit) begin
                victim_way <= lfsr[0];
            end
            if (state == REPLACE) begin
                refill_cnt <= '0;
            end else if (refill_we) begin
                refill_cnt <= refill_cnt + 1'b1;
            end
            if (refill_we && ret_last) begin
                lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
            end
        end
    end

    assign way0_hit  = way0.rd_valid && (way0.rd_tag == req_tag);
    assign way1_hit  = way1.rd_valid && (way1.rd_tag == req_tag);
    assign hit       = way0_hit || way1_hit;
    assign hit_block = way1_hit ? way1.rd_block : way0.rd_block;
    assign hit_word  = hit_block[req_bank * `WORD_W +: `WORD_W];

    // Store bytes of a write miss land in the refilled word
    always_comb begin
        refill_word = ret_data;
        if (req_op == OP_WRITE && refill_cnt == req_bank) begin
            for (int i = 0; i < `STRB_W; i++) begin
                if (req_wstrb[i]) begin
                    refill_word[8*i +: 8] = req_wdata[8*i +: 8];
                end
            end
        end
    end

    assign rdata   = (state == REFILL) ? refill_word : hit_word;
    assign data_ok = ((state == LOOKUP) && (hit || req_op == OP_WRITE)) ||
                     (refill_we && (refill_cnt == req_bank) && (req_op == OP_READ));

    // Victim data was re-read in LOOKUP and holds through MISS
    assign victim_tag   = victim_way ? way1.rd_tag : way0.rd_tag;
    assign victim_dirty = victim_way ? (way1.rd_valid && way1.rd_dirty)
                                     : (way0.rd_valid && way0.rd_dirty);

    assign wr_req  = (state == MISS) && victim_dirty;
    assign wr_addr = {victim_tag, req_index, offset_t'(0)};
    assign wr_data = victim_way ? way1.rd_block : way0.rd_block;
    assign rd_req  = (state == REPLACE);
    assign rd_addr = {req_tag, req_index, offset_t'(0)};

    assign hw.capture = (state == LOOKUP) && (req_op == OP_WRITE) && hit;
    assign hw.way     = way1_hit;
    assign hw.bank    = req_bank;
    assign hw.index   = req_index;
    assign hw.strb    = req_wstrb;
    assign hw.data    = req_wdata;

    assign refill_we  = (state == REFILL) && ret_valid;
    assign tag_we     = refill_we && ret_last;
    assign refill_sel = {victim_way, !victim_way};
    assign hit_sel    = {hw.wb_way, !hw.wb_way} & {2{hw.active}};

    assign rd_en      = accept || (state == LOOKUP);
    assign rd_index   = (state == IDLE) ? index : req_index;
    assign wr_index   = (state == REFILL) ? req_index : hw.wb_index;
    assign bank_wdata = (state == REFILL) ? refill_word : hw.wb_data;

    always_comb begin
        for (int b = 0; b < `BANKS; b++) begin
            refill_bank_we[b] = (refill_we && refill_cnt == b) ? '1 : '0;
            hit_bank_we[b]    = (hw.wb_bank == b) ? hw.wb_strb : '0;
        end
    end

    assign way0.en         = rd_en;
    assign way0.index      = rd_index;
    assign way0.wr_index   = wr_index;
    assign way0.tagv_we    = tag_we && refill_sel[0];
    assign way0.tagv_wdata = {req_tag, 1'b1};
    assign way0.bank_we    = ({(`BANKS*`STRB_W){refill_sel[0]}} & refill_bank_we) |
                             ({(`BANKS*`STRB_W){hit_sel[0]}} & hit_bank_we);
    assign way0.bank_wdata = bank_wdata;
    assign way0.dirty_set  = (tag_we && refill_sel[0] && req_op == OP_WRITE) || hit_sel[0];
    assign way0.dirty_clr  = tag_we && refill_sel[0] && (req_op == OP_READ);

    assign way1.en         = rd_en;
    assign way1.index      = rd_index;
    assign way1.wr_index   = wr_index;
    assign way1.tagv_we    = tag_we && refill_sel[1];
    assign way1.tagv_wdata = {req_tag, 1'b1};
    assign way1.bank_we    = ({(`BANKS*`STRB_W){refill_sel[1]}} & refill_bank_we) |
                             ({(`BANKS*`STRB_W){hit_sel[1]}} & hit_bank_we);
    assign way1.bank_wdata = bank_wdata;
    assign way1.dirty_set  = (tag_we && refill_sel[1] && req_op == OP_WRITE) || hit_sel[1];
    assign way1.dirty_clr  = tag_we && refill_sel[1] && (req_op == OP_READ);

endmodule

//--- logic/hit_write_buffer.sv
// Store hit buffer
// Holds one hit store and writes it the cycle after lookup
module hit_write_buffer
    import cache_addr_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    hit_write_if.buffer hw
);

    wb_state_t state;
    wb_state_t state_next;

    way_t   way_q;
    bank_t  bank_q;
    index_t index_q;
    strb_t  strb_q;
    word_t  data_q;

    // Stays in WB_WRITE only while captures keep arriving
    assign state_next = hw.capture ? WB_WRITE : WB_IDLE;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= WB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (hw.capture) begin
            way_q   <= hw.way;
            bank_q  <= hw.bank;
            index_q <= hw.index;
            strb_q  <= hw.strb;
            data_q  <= hw.data;
        end
    end

    assign hw.active   = (state == WB_WRITE);
    assign hw.wb_way   = way_q;
    assign hw.wb_bank  = bank_q;
    assign hw.wb_index = index_q;
    assign hw.wb_strb  = strb_q;
    assign hw.wb_data  = data_q;

endmodule

//--- logic/cache_way.sv
// One cache way
// Tag and valid array, four byte-writable data banks and the dirty table
`include "cache_defines.svh"

module cache_way
    import cache_addr_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    cache_way_if.way    p
);

    tag_t                   tag_mem  [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_mem;
    logic [`CACHE_SETS-1:0] dirty_mem;
    word_t                  bank_mem [`BANKS][`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tag_mem[s] <= '0;
                for (int b = 0; b < `BANKS; b++) begin
                    bank_mem[b][s] <= '0;
                end
            end
            valid_mem <= '0;
            dirty_mem <= '0;
        end else begin
            if (p.tagv_we) begin
                tag_mem[p.wr_index]   <= p.tagv_wdata[`TAG_W:1];
                valid_mem[p.wr_index] <= p.tagv_wdata[0];
            end
            for (int b = 0; b < `BANKS; b++) begin
                for (int i = 0; i < `STRB_W; i++) begin
                    if (p.bank_we[b][i]) begin
                        bank_mem[b][p.wr_index][8*i +: 8] <= p.bank_wdata[8*i +: 8];
                    end
                end
            end
            if (p.dirty_set) begin
                dirty_mem[p.wr_index] <= 1'b1;
            end else if (p.dirty_clr) begin
                dirty_mem[p.wr_index] <= 1'b0;
            end
        end
    end

    // Read data holds while en is low
    always_ff @(posedge clk) begin
        if (p.en) begin
            p.rd_tag   <= tag_mem[p.index];
            p.rd_valid <= valid_mem[p.index];
            p.rd_dirty <= dirty_mem[p.index];
            for (int b = 0; b < `BANKS; b++) begin
                p.rd_block[b*`WORD_W +: `WORD_W] <= bank_mem[b][p.index];
            end
        end
    end

endmodule

//--- logic/cache_ifs.sv
// Internal cache interfaces
// Way RAM port and the handoff to the hit store buffer
`include "cache_defines.svh"

interface cache_way_if
    import cache_addr_pkg::*;
();
    logic               en;             // Read enable
    index_t             index;          // Read set
    index_t             wr_index;       // Write set, shared by tag, bank and dirty writes
    logic               tagv_we;
    logic [`TAG_W:0]    tagv_wdata;     // {tag, valid}
    strb_t [`BANKS-1:0] bank_we;        // Byte strobes per bank
    word_t              bank_wdata;
    logic               dirty_set;
    logic               dirty_clr;

    tag_t               rd_tag;
    logic               rd_valid;
    block_t             rd_block;
    logic               rd_dirty;

    modport ctrl (
        output en, index, wr_index, tagv_we, tagv_wdata, bank_we, bank_wdata,
               dirty_set, dirty_clr,
        input  rd_tag, rd_valid, rd_block, rd_dirty
    );

    modport way (
        input  en, index, wr_index, tagv_we, tagv_wdata, bank_we, bank_wdata,
               dirty_set, dirty_clr,
        output rd_tag, rd_valid, rd_block, rd_dirty
    );
endinterface

interface hit_write_if
    import cache_addr_pkg::*;
();
    logic   capture;        // Store hit seen in LOOKUP
    way_t   way;
    bank_t  bank;
    index_t index;
    strb_t  strb;
    word_t  data;

    logic   active;         // Pending store is written this cycle
    way_t   wb_way;
    bank_t  wb_bank;
    index_t wb_index;
    strb_t  wb_strb;
    word_t  wb_data;

    modport src (
        output capture, way, bank, index, strb, data,
        input  active, wb_way, wb_bank, wb_index, wb_strb, wb_data
    );

    modport buffer (
        input  capture, way, bank, index, strb, data,
        output active, wb_way, wb_bank, wb_index, wb_strb, wb_data
    );
endinterface

//--- logic/cache_ctrl_pkg.sv
// Control types for the data cache
// Main and store buffer FSM states, CPU operation
package cache_ctrl_pkg;

    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,     // Victim write-back
        REPLACE = 5'b01000,     // Line read request
        REFILL  = 5'b10000
    } main_state_t;

    typedef enum logic [1:0] {
        WB_IDLE  = 2'b01,
        WB_WRITE = 2'b10
    } wb_state_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cpu_op_t;

endpackage

//--- logic/cache_addr_pkg.sv
// Address field and data width types for the data cache
`include "cache_defines.svh"

package cache_addr_pkg;

    typedef logic [`INDEX_W-1:0]        index_t;    // Set number
    typedef logic [`TAG_W-1:0]          tag_t;      // Physical tag
    typedef logic [`OFFSET_W-1:0]       offset_t;
    typedef logic [$clog2(`BANKS)-1:0]  bank_t;     // Word within a line

    typedef logic [`WORD_W-1:0]         word_t;
    typedef logic [`BLOCK_W-1:0]        block_t;    // Whole line
    typedef logic [`STRB_W-1:0]         strb_t;     // Byte enables

    // Only two ways
    typedef logic                       way_t;

endpackage

//--- logic/cache_defines.svh
// Cache geometry and datapath widths
// Two ways of 256 sets, 16-byte lines split into four word banks
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

`define CACHE_SETS  256         // Sets per way
`define INDEX_W     8
`define TAG_W       20
`define OFFSET_W    4           // Byte offset within a line

`define BANKS       4           // Words per line
`define WORD_W      32
`define BLOCK_W     128
`define STRB_W      4

// Victim LFSR value after reset
`define LFSR_SEED   3'b111

`endif
